// File: Makefile
# Verilator build, run and lint for the execute stage

VERILATOR  ?= verilator
TB_TOP     ?= ex_stage_tb
RTL_TOP    ?= ex_stage
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/ex_alu.sv
////////////////////////////////////////////////////////////////////////////
// integer alu
// single cycle rv32i operations plus the rv32m multiplies, run on the
// iterative multiplier under a two state controller that honours
// result bus back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_alu #(
	parameter int mult_bits_per_cycle = 8
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        valid_in,
	input  logic                        cdb_busy,
	input  rv_isa_pkg::alu_func_t       func,
	input  logic [rv_isa_pkg::xlen-1:0] opa,
	input  logic [rv_isa_pkg::xlen-1:0] opb,
	output logic                        occupied,
	output logic                        valid_out,
	output logic [rv_isa_pkg::xlen-1:0] result
);

	typedef enum logic {idle, multiplying} alu_state_t;

	alu_state_t                      state, next_state;
	logic                            is_mult;
	logic                            start;
	logic                            mult_done;
	logic [1:0]                      sign_mode;
	logic                            high_half, high_half_r;	// product [63:32]
	logic [2*rv_isa_pkg::xlen-1:0]   product;
	logic [rv_isa_pkg::xlen-1:0]     alu_out;
	logic [rv_isa_pkg::xlen-1:0]     mult_out;

	assign is_mult = (func == rv_isa_pkg::alu_mul) || (func == rv_isa_pkg::alu_mulh) ||
		(func == rv_isa_pkg::alu_mulhsu) || (func == rv_isa_pkg::alu_mulhu);

	ex_multiplier #(
		.mult_bits_per_cycle(mult_bits_per_cycle)
	) i_mult (
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.sign_mode (sign_mode),
		.mcand     (opa),
		.mplier    (opb),
		.product   (product),
		.done      (mult_done)
	);

	////////////////////////////////////////////////////////////////////////////
	// controller
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		valid_out  = 1'b0;
		start      = 1'b0;
		case (state)
			idle: begin
				if (valid_in && !cdb_busy) begin	// bus free, accept
					if (is_mult) begin
						start      = 1'b1;
						next_state = multiplying;
					end else begin
						valid_out = 1'b1;	// combinational result
					end
				end
			end
			multiplying: begin
				if (mult_done && !cdb_busy) begin
					valid_out  = 1'b1;
					next_state = idle;
				end
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	// half choice captured with the operands
	always_ff @(posedge clock) begin
		if (start)
			high_half_r <= high_half;
	end

	assign occupied = (state == multiplying);
	assign mult_out = high_half_r ? product[2*rv_isa_pkg::xlen-1:rv_isa_pkg::xlen]
		: product[rv_isa_pkg::xlen-1:0];
	assign result = occupied ? mult_out : alu_out;

	// single cycle ops and multiply modes
	always_comb begin
		alu_out   = '0;
		sign_mode = 2'b00;
		high_half = 1'b0;
		case (func)
			rv_isa_pkg::alu_add:  alu_out = opa + opb;
			rv_isa_pkg::alu_sub:  alu_out = opa - opb;
			rv_isa_pkg::alu_and:  alu_out = opa & opb;
			rv_isa_pkg::alu_or:   alu_out = opa | opb;
			rv_isa_pkg::alu_xor:  alu_out = opa ^ opb;
			rv_isa_pkg::alu_slt:  alu_out[0] = $signed(opa) < $signed(opb);
			rv_isa_pkg::alu_sltu: alu_out[0] = opa < opb;
			rv_isa_pkg::alu_sll:  alu_out = opa << opb[4:0];
			rv_isa_pkg::alu_srl:  alu_out = opa >> opb[4:0];
			rv_isa_pkg::alu_sra:  alu_out = $signed(opa) >>> opb[4:0];	// keeps sign
			rv_isa_pkg::alu_mul:  sign_mode = 2'b11;	// low half same for any sign
			rv_isa_pkg::alu_mulh: begin
				sign_mode = 2'b11;
				high_half = 1'b1;
			end
			rv_isa_pkg::alu_mulhsu: begin
				sign_mode = 2'b01;	// rs1 signed, rs2 unsigned
				high_half = 1'b1;
			end
			rv_isa_pkg::alu_mulhu: begin
				sign_mode = 2'b00;
				high_half = 1'b1;
			end
			default: alu_out = 32'hfacebeec;	// unused func code
		endcase
	end

endmodule

// File: hdl/ex_multiplier.sv
////////////////////////////////////////////////////////////////////////////
// iterative 32x32 multiplier
// signed or unsigned operands, 64 bit product, retires a fixed number
// of multiplier bits per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_multiplier #(
	parameter int mult_bits_per_cycle = 8
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          start,
	input  logic [1:0]                    sign_mode,	// [1] mplier signed, [0] mcand signed
	input  logic [rv_isa_pkg::xlen-1:0]   mcand,
	input  logic [rv_isa_pkg::xlen-1:0]   mplier,
	output logic [2*rv_isa_pkg::xlen-1:0] product,
	output logic                          done
);

	localparam int steps = rv_isa_pkg::xlen / mult_bits_per_cycle;
	localparam int cnt_bits = $clog2(steps + 1);

	logic [2*rv_isa_pkg::xlen-1:0] mcand_r;	// shifts left each step
	logic [rv_isa_pkg::xlen-1:0]   mplier_r;	// shifts right each step
	logic [2*rv_isa_pkg::xlen-1:0] prod_r;
	logic [mult_bits_per_cycle-1:0] chunk;
	logic [cnt_bits-1:0]           count;

	assign chunk = mplier_r[mult_bits_per_cycle-1:0];
	assign product = prod_r;

	////////////////////////////////////////////////////////////////////////////
	// datapath
	// only the low 32 mplier bits are stepped, a negative mplier is handled
	// by starting the sum at -(mcand << 32)
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (start) begin
			if (sign_mode[0])
				mcand_r <= {{rv_isa_pkg::xlen{mcand[rv_isa_pkg::xlen-1]}}, mcand};
			else
				mcand_r <= {{rv_isa_pkg::xlen{1'b0}}, mcand};
			mplier_r <= mplier;
			if (sign_mode[1] && mplier[rv_isa_pkg::xlen-1])
				prod_r <= '0 - {mcand, {rv_isa_pkg::xlen{1'b0}}};	// weight -2^32 of bit 31
			else
				prod_r <= '0;
		end else if (count != '0) begin
			prod_r   <= prod_r + mcand_r * chunk;	// partial product, mod 2^64
			mcand_r  <= mcand_r << mult_bits_per_cycle;
			mplier_r <= mplier_r >> mult_bits_per_cycle;
		end
	end

	// step counter and done flag
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			done  <= 1'b0;
		end else if (start) begin
			count <= cnt_bits'(steps);
			done  <= 1'b0;
		end else if (count != '0) begin
			count <= count - 1'b1;
			done  <= (count == cnt_bits'(1));	// last step, stays set
		end
	end

endmodule

// File: hdl/ex_operand_decode.sv
////////////////////////////////////////////////////////////////////////////
// execute operand decode
// builds the rv32 immediates from the instruction word and selects
// operand a and operand b for the alu
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_operand_decode (
	input  ex_types_pkg::issue_packet_t issue_in,
	output logic [rv_isa_pkg::xlen-1:0] opa,
	output logic [rv_isa_pkg::xlen-1:0] opb
);

	logic [rv_isa_pkg::xlen-1:0] inst;
	logic                        sign;
	logic [rv_isa_pkg::xlen-1:0] i_imm;
	logic [rv_isa_pkg::xlen-1:0] s_imm;
	logic [rv_isa_pkg::xlen-1:0] b_imm;
	logic [rv_isa_pkg::xlen-1:0] u_imm;
	logic [rv_isa_pkg::xlen-1:0] j_imm;

	assign inst = issue_in.inst;
	assign sign = inst[rv_isa_pkg::imm_sign];

	////////////////////////////////////////////////////////////////////////////
	// immediates, all sign extended from bit 31
	////////////////////////////////////////////////////////////////////////////
	assign i_imm = {{20{sign}}, inst[31:20]};
	assign s_imm = {{20{sign}}, inst[31:25], inst[11:7]};
	assign b_imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};	// halfword aligned
	assign u_imm = {inst[31:12], 12'b0};	// upper 20, nothing to extend
	assign j_imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};

	// operand a mux
	always_comb begin
		opa = 32'hdeadfbac;	// filler, shows a bad select
		case (issue_in.opa_select)
			ex_types_pkg::opa_is_rs1:  opa = issue_in.rs1_value;
			ex_types_pkg::opa_is_npc:  opa = issue_in.npc;
			ex_types_pkg::opa_is_pc:   opa = issue_in.pc;	// auipc, branch target
			ex_types_pkg::opa_is_zero: opa = '0;	// lui
			default:                   opa = 32'hdeadfbac;
		endcase
	end

	// operand b mux
	always_comb begin
		opb = 32'hfacefeed;
		case (issue_in.opb_select)
			ex_types_pkg::opb_is_rs2:   opb = issue_in.rs2_value;
			ex_types_pkg::opb_is_i_imm: opb = i_imm;
			ex_types_pkg::opb_is_s_imm: opb = s_imm;	// store address
			ex_types_pkg::opb_is_b_imm: opb = b_imm;
			ex_types_pkg::opb_is_u_imm: opb = u_imm;
			ex_types_pkg::opb_is_j_imm: opb = j_imm;
			default:                    opb = 32'hfacefeed;	// codes 6, 7
		endcase
	end

endmodule

// File: hdl/ex_result.sv
////////////////////////////////////////////////////////////////////////////
// execute result
// resolves the branch condition and builds the outgoing execute packet
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_result (
	input  ex_types_pkg::issue_packet_t issue_in,
	input  logic                        alu_valid,
	input  logic [rv_isa_pkg::xlen-1:0] alu_result,
	output ex_types_pkg::ex_packet_t    ex_out
);

	logic [2:0] funct3;
	logic       cond;	// condition true
	logic [rv_isa_pkg::xlen-1:0] rs1, rs2;

	assign funct3 = issue_in.inst[rv_isa_pkg::funct3_hi:rv_isa_pkg::funct3_lo];
	assign rs1 = issue_in.rs1_value;
	assign rs2 = issue_in.rs2_value;

	// branch condition
	always_comb begin
		cond = 1'b0;
		case (funct3)
			rv_isa_pkg::br_beq:  cond = (rs1 == rs2);
			rv_isa_pkg::br_bne:  cond = (rs1 != rs2);
			rv_isa_pkg::br_blt:  cond = ($signed(rs1) < $signed(rs2));
			rv_isa_pkg::br_bge:  cond = ($signed(rs1) >= $signed(rs2));
			rv_isa_pkg::br_bltu: cond = (rs1 < rs2);
			rv_isa_pkg::br_bgeu: cond = (rs1 >= rs2);
			default:             cond = 1'b0;	// 010, 011 not branches
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// outgoing packet
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		ex_out.valid       = alu_valid;
		ex_out.alu_result  = alu_result;	// target for branches and jumps
		ex_out.npc         = issue_in.npc;	// link value
		ex_out.rs2_value   = issue_in.rs2_value;
		ex_out.take_branch = issue_in.uncond_branch | (issue_in.cond_branch & cond);
		ex_out.dest_tag    = issue_in.dest_tag;
		ex_out.rob_idx     = issue_in.rob_idx;
	end

endmodule

// File: hdl/ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// execute stage top
// operand decode, alu with multiplier, and result assembly
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage #(
	parameter int mult_bits_per_cycle = 8	// 4 cycle multiply
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        cdb_busy,
	input  ex_types_pkg::issue_packet_t issue_in,
	output ex_types_pkg::ex_packet_t    ex_out,
	output logic                        occupied	// issuer holds packet
);

	logic [rv_isa_pkg::xlen-1:0] opa, opb;
	logic                        alu_valid;
	logic [rv_isa_pkg::xlen-1:0] alu_result;

	ex_operand_decode i_decode (
		.issue_in (issue_in),
		.opa      (opa),
		.opb      (opb)
	);

	ex_alu #(
		.mult_bits_per_cycle(mult_bits_per_cycle)
	) i_alu (
		.clock     (clock),
		.reset     (reset),
		.valid_in  (issue_in.valid),
		.cdb_busy  (cdb_busy),
		.func      (issue_in.alu_func),
		.opa       (opa),
		.opb       (opb),
		.occupied  (occupied),
		.valid_out (alu_valid),
		.result    (alu_result)
	);

	ex_result i_result (
		.issue_in   (issue_in),
		.alu_valid  (alu_valid),
		.alu_result (alu_result),
		.ex_out     (ex_out)
	);

endmodule

// File: hdl/ex_types_pkg.sv
////////////////////////////////////////////////////////////////////////////
// execute stage packet types
// operand select codes and the packets passed from issue into execute
// and from execute on to writeback
////////////////////////////////////////////////////////////////////////////

package ex_types_pkg;

	localparam int tag_bits = 6;	// physical register tag
	localparam int rob_bits = 5;	// reorder buffer index

	// operand a source
	typedef enum logic [1:0] {
		opa_is_rs1  = 2'd0,
		opa_is_npc  = 2'd1,
		opa_is_pc   = 2'd2,
		opa_is_zero = 2'd3
	} opa_sel_t;

	// operand b source, codes 6 and 7 unused
	typedef enum logic [2:0] {
		opb_is_rs2   = 3'd0,
		opb_is_i_imm = 3'd1,
		opb_is_s_imm = 3'd2,
		opb_is_b_imm = 3'd3,
		opb_is_u_imm = 3'd4,
		opb_is_j_imm = 3'd5
	} opb_sel_t;

	////////////////////////////////////////////////////////////////////////////
	// issue -> execute
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                           valid;
		logic [rv_isa_pkg::xlen-1:0]    inst;
		logic [rv_isa_pkg::xlen-1:0]    pc;
		logic [rv_isa_pkg::xlen-1:0]    npc;	// pc + 4
		logic [rv_isa_pkg::xlen-1:0]    rs1_value;
		logic [rv_isa_pkg::xlen-1:0]    rs2_value;
		opa_sel_t                       opa_select;
		opb_sel_t                       opb_select;
		rv_isa_pkg::alu_func_t          alu_func;
		logic                           cond_branch;
		logic                           uncond_branch;	// jal / jalr
		logic [tag_bits-1:0]            dest_tag;
		logic [rob_bits-1:0]            rob_idx;
	} issue_packet_t;

	// execute -> writeback
	typedef struct packed {
		logic                           valid;
		logic [rv_isa_pkg::xlen-1:0]    alu_result;
		logic [rv_isa_pkg::xlen-1:0]    npc;
		logic [rv_isa_pkg::xlen-1:0]    rs2_value;	// store data
		logic                           take_branch;
		logic [tag_bits-1:0]            dest_tag;
		logic [rob_bits-1:0]            rob_idx;
	} ex_packet_t;

endpackage

// File: hdl/rv_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// rv32 isa definitions
// word width, alu function codes, branch funct3 codes and the
// instruction field positions used by the execute stage
////////////////////////////////////////////////////////////////////////////

package rv_isa_pkg;

	localparam int xlen = 32;	// rv32, immediate layouts depend on it

	// instruction word field positions
	localparam int funct3_lo = 12;
	localparam int funct3_hi = 14;
	localparam int imm_sign = 31;	// sign bit of every immediate format

	////////////////////////////////////////////////////////////////////////////
	// alu function codes
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_slt    = 4'd5,
		alu_sltu   = 4'd6,
		alu_sll    = 4'd7,
		alu_srl    = 4'd8,
		alu_sra    = 4'd9,
		alu_mul    = 4'd10,	// low half
		alu_mulh   = 4'd11,	// signed x signed, high half
		alu_mulhsu = 4'd12,	// signed x unsigned, high half
		alu_mulhu  = 4'd13	// unsigned x unsigned, high half
	} alu_func_t;

	// branch condition funct3
	localparam logic [2:0] br_beq  = 3'b000;
	localparam logic [2:0] br_bne  = 3'b001;
	localparam logic [2:0] br_blt  = 3'b100;
	localparam logic [2:0] br_bge  = 3'b101;
	localparam logic [2:0] br_bltu = 3'b110;
	localparam logic [2:0] br_bgeu = 3'b111;

endpackage

// File: test/ex_cases.txt
# name inst pc npc rs1 rs2 opa_sel opb_sel func cond uncond busy result take
# numbers in hex, func 0-9 single cycle, 10-13 mul mulh mulhsu mulhu
add_ovf    00000033 00001000 00001004 7fffffff 00000001 0 0 0 0 0 0 80000000 0
sub_neg    40000033 00001000 00001004 00000003 00000005 0 0 1 0 0 0 fffffffe 0
and_rr     00007033 00001000 00001004 f0f0ff00 0ff0f0f0 0 0 2 0 0 0 00f0f000 0
or_rr      00006033 00001000 00001004 f0f0ff00 0ff0f0f0 0 0 3 0 0 0 fff0fff0 0
xor_rr     00004033 00001000 00001004 f0f0ff00 0ff0f0f0 0 0 4 0 0 0 ff000ff0 0
slt_neg    00002033 00001000 00001004 ffffffff 00000001 0 0 5 0 0 0 00000001 0
sltu_big   00003033 00001000 00001004 ffffffff 00000001 0 0 6 0 0 0 00000000 0
sll_mask   00001033 00001000 00001004 00000001 0000003f 0 0 7 0 0 0 80000000 0
srl_msb    00005033 00001000 00001004 80000000 00000004 0 0 8 0 0 0 08000000 0
sra_neg    40005033 00001000 00001004 80000000 00000004 0 0 9 0 0 0 f8000000 0
lui_imm    123450b7 00001000 00001004 00000000 00000000 3 4 0 0 0 0 12345000 0
auipc_neg  fffff097 00002000 00002004 00000000 00000000 2 4 0 0 0 0 00001000 0
addi_neg   fff10093 00001000 00001004 00000010 00000000 0 1 0 0 0 0 0000000f 0
npc_imm    00400013 00001000 00001004 00000000 00000000 1 1 0 0 0 0 00001008 0
jal_back   ff9ff0ef 00001000 00001004 00000000 00000000 2 5 0 0 1 0 00000ff8 1
sw_addr    fe512e23 00001000 00001004 00001000 cafef00d 0 2 0 0 0 0 00000ffc 0
beq_taken  fe2088e3 00002000 00002004 00000005 00000005 2 3 0 1 0 0 00001ff0 1
beq_not    00208463 00003000 00003004 00000005 00000006 2 3 0 1 0 0 00003008 0
bne_taken  00209463 00003000 00003004 00000005 00000006 2 3 0 1 0 0 00003008 1
blt_sign   0020c463 00003000 00003004 80000000 00000001 2 3 0 1 0 0 00003008 1
bge_sign   0020d463 00003000 00003004 80000000 00000001 2 3 0 1 0 0 00003008 0
bltu_not   0020e463 00003000 00003004 80000000 00000001 2 3 0 1 0 0 00003008 0
bgeu_taken 0020f463 00003000 00003004 80000000 00000001 2 3 0 1 0 0 00003008 1
mul_neg    02000033 00001000 00001004 fffffffd 00000007 0 0 a 0 0 0 ffffffeb 0
mulh_min   02001033 00001000 00001004 80000000 80000000 0 0 b 0 0 0 40000000 0
mulhsu_neg 02002033 00001000 00001004 ffffffff ffffffff 0 0 c 0 0 0 ffffffff 0
mulhsu_pos 02002033 00001000 00001004 00000002 80000000 0 0 c 0 0 0 00000001 0
mulhu_max  02003033 00001000 00001004 ffffffff ffffffff 0 0 d 0 0 0 fffffffe 0
add_busy   00000033 00001000 00001004 00000005 00000007 0 0 0 0 0 2 0000000c 0
mul_busy   02000033 00001000 00001004 12345678 00000010 0 0 a 0 0 3 23456780 0
mulhu_busy 02003033 00001000 00001004 80000000 00000004 0 0 d 0 0 5 00000002 0

// File: test/ex_stage_tb.sv
////////////////////////////////////////////////////////////////////////////
// execute stage testbench
// reads one case per line from the cases file, drives the issue packet
// on the falling edge, waits for the execute packet and compares it
// with the expected values from the file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage_tb;

	localparam int half_period = 50;	// 100 ns clock
	localparam int quarter = 25;	// sample point, half a phase after the drive
	localparam int reset_cycles = 8;
	localparam int mult_latency = 32 / 8;	// 8 multiplier bits per cycle at the top
	localparam int busy_start = 3;	// multiply back-pressure goes up before done
	localparam int wait_limit = 40;

	logic                        clock;
	logic                        reset;
	logic                        cdb_busy;
	ex_types_pkg::issue_packet_t issue_in;
	ex_types_pkg::ex_packet_t    ex_out;
	logic                        occupied;

	// case file fields
	integer          fd;
	integer          fields;
	logic [8*200-1:0] line;
	logic [8*16-1:0] test_name;
	logic [31:0]     f_inst, f_pc, f_npc, f_rs1, f_rs2;
	logic [31:0]     f_opa, f_opb, f_func, f_cond, f_uncond;
	logic [31:0]     f_busy, f_result, f_take;
	integer          seed;
	integer          cases_run;

	ex_stage i_dut (
		.clock    (clock),
		.reset    (reset),
		.cdb_busy (cdb_busy),
		.issue_in (issue_in),
		.ex_out   (ex_out),
		.occupied (occupied)
	);

	always #half_period clock = ~clock;

	task automatic compare(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %0s, %0s: expected %h, actual %h",
				test_name, what, expected, actual);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one case: present the packet, hold it, wait for ex_out.valid
	////////////////////////////////////////////////////////////////////////////
	task automatic run_case();
		ex_types_pkg::issue_packet_t pkt;
		logic is_mult;
		int   busy_from;
		int   exp_index;
		int   k;
		logic seen;

		pkt               = '0;
		pkt.valid         = 1'b1;
		pkt.inst          = f_inst;
		pkt.pc            = f_pc;
		pkt.npc           = f_npc;
		pkt.rs1_value     = f_rs1;
		pkt.rs2_value     = f_rs2;
		pkt.opa_select    = ex_types_pkg::opa_sel_t'(f_opa[1:0]);
		pkt.opb_select    = ex_types_pkg::opb_sel_t'(f_opb[2:0]);
		pkt.alu_func      = rv_isa_pkg::alu_func_t'(f_func[3:0]);
		pkt.cond_branch   = f_cond[0];
		pkt.uncond_branch = f_uncond[0];
		pkt.dest_tag      = 6'(cases_run + 1);	// arbitrary, only passed through
		pkt.rob_idx       = 5'(cases_run * 7);
		is_mult = (pkt.alu_func == rv_isa_pkg::alu_mul) ||
			(pkt.alu_func == rv_isa_pkg::alu_mulh) ||
			(pkt.alu_func == rv_isa_pkg::alu_mulhsu) ||
			(pkt.alu_func == rv_isa_pkg::alu_mulhu);
		// single cycle ops see busy from the start, multiplies after acceptance
		busy_from = is_mult ? busy_start : 0;
		exp_index = busy_from + int'(f_busy);
		if (is_mult && exp_index < mult_latency + 1)
			exp_index = mult_latency + 1;	// accepted at edge 1, done 4 edges later
		seen = 1'b0;
		k = 0;
		while (!seen) begin
			if (k == wait_limit) begin
				$display("timeout: %0s gave no ex_out.valid within %0d cycles",
					test_name, wait_limit);
				$display("Test failures found");
				$fatal(1);
			end else begin
				@(negedge clock);
				issue_in = pkt;	// held while occupied
				cdb_busy = (k >= busy_from) && (k < busy_from + int'(f_busy));
				#quarter;
				if (ex_out.valid) begin
					seen = 1'b1;
				end else begin
					compare("occupied while waiting", 32'(is_mult && (k >= 1)),
						32'(occupied));
					k++;
				end
			end
		end
		compare("result cycle", 32'(exp_index), 32'(k));
		compare("alu_result", f_result, ex_out.alu_result);
		compare("take_branch", f_take, 32'(ex_out.take_branch));
		compare("npc", f_npc, ex_out.npc);
		compare("rs2_value", f_rs2, ex_out.rs2_value);
		compare("dest_tag", 32'(pkt.dest_tag), 32'(ex_out.dest_tag));
		compare("rob_idx", 32'(pkt.rob_idx), 32'(ex_out.rob_idx));
		compare("occupied with result", 32'(is_mult), 32'(occupied));
		// packet withdrawn, controller back to idle
		@(negedge clock);
		issue_in = '0;
		cdb_busy = 1'b0;
		#quarter;
		compare("occupied after result", 32'd0, 32'(occupied));
		compare("valid after result", 32'd0, 32'(ex_out.valid));
	endtask

	// random idle gap, bus toggling, nothing issued
	task automatic idle_gap();
		int     n;
		integer draw;

		n = $random(seed) & 3;
		for (int i = 0; i < n; i++) begin
			@(negedge clock);
			draw = $random(seed);
			issue_in = '0;
			cdb_busy = draw[0];
			#quarter;
			compare("valid while idle", 32'd0, 32'(ex_out.valid));
			compare("occupied while idle", 32'd0, 32'(occupied));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		clock = 1'b0;
		reset = 1'b1;
		cdb_busy = 1'b0;
		issue_in = '0;
		seed = 4787;
		cases_run = 0;
		test_name = "reset";
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		#quarter;
		compare("valid after reset", 32'd0, 32'(ex_out.valid));
		compare("occupied after reset", 32'd0, 32'(occupied));
		fd = $fopen("test/ex_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open test/ex_cases.txt");
			$display("Test failures found");
			$fatal(1);
		end else begin
			while ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
					test_name, f_inst, f_pc, f_npc, f_rs1, f_rs2, f_opa, f_opb,
					f_func, f_cond, f_uncond, f_busy, f_result, f_take);
				if (fields == 14) begin	// comment and blank lines fall out here
					run_case();
					idle_gap();
					cases_run++;
				end
			end
			$fclose(fd);
			if (cases_run == 0) begin
				$display("no cases found in test/ex_cases.txt");
				$display("Test failures found");
				$fatal(1);
			end else begin
				$display("All tests passed!");
				$finish;
			end
		end
	end

endmodule

// File: verilog.f
hdl/rv_isa_pkg.sv
hdl/ex_types_pkg.sv
hdl/ex_operand_decode.sv
hdl/ex_multiplier.sv
hdl/ex_alu.sv
hdl/ex_result.sv
hdl/ex_stage.sv
test/ex_stage_tb.sv
